// File: logic/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Virtual word address width.
`define CORE_PC_W 28
// Instruction and data word width.
`define CORE_INST_W 32
// First PC out of reset.
`define CORE_RESET_PC 0

// Direct-mapped instruction cache geometry.
`define ICACHE_LINES 16
`define ICACHE_LINE_WORDS 4

// Implemented memory address bits, upper bits ignored.
`define MEM_AW 10
// Cycles from an accepted read to its response.
`define MEM_RD_LAT 2

`endif

// File: logic/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

  // Request toward main memory.
  // Driven by whichever client owns the bus.
  typedef struct packed {
    logic                    valid;
    logic                    we;
    logic [`CORE_PC_W-1:0]   addr;
    logic [`CORE_INST_W-1:0] wdata;
  } mem_req_t;

  // Response from main memory.
  // Broadcast to all clients, valid is a one-cycle pulse.
  typedef struct packed {
    logic                    valid;
    logic [`CORE_INST_W-1:0] rdata;
  } mem_rsp_t;

  // Fetch to decode payload.
  typedef struct packed {
    logic [`CORE_INST_W-1:0] inst;
    logic [`CORE_PC_W-1:0]   pc;
  } f2d_t;

endpackage

// File: logic/fetch_stage.sv
`include "core_defines.svh"

module fetch_stage import core_pkg::*; (
  input  logic                    clkrst_core_clk,
  input  logic                    clkrst_core_rst_n,
  input  logic [`CORE_PC_W-1:0]   pc2f_newpc,
  input  logic                    pipe_flush,
  input  logic                    f_valid_in,
  input  logic                    f_out_ok,
  input  logic                    ic2f_ready,
  input  logic [`CORE_INST_W-1:0] ic2f_inst,
  output logic [`CORE_PC_W-1:0]   f2ic_vaddr,
  output logic                    f2ic_valid,
  output logic                    f_ready_out,
  output logic                    f_valid_out,
  output f2d_t                    f2d
);

  localparam int PC_W = `CORE_PC_W;

  // PC of the next request.
  logic [PC_W-1:0] virtpc;
  // PC of the read in flight.
  logic [PC_W-1:0] virtpc_1a;
  // Set when the read in flight is a real one.
  logic            valid_inprogress;
  logic            accept;

  assign accept = f2ic_valid && ic2f_ready;

  // Flush wins over a same-cycle acceptance.
  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      virtpc           <= PC_W'(`CORE_RESET_PC);
      valid_inprogress <= 1'b0;
    end else if (pipe_flush) begin
      virtpc           <= pc2f_newpc;
      valid_inprogress <= 1'b0;
    end else if (accept) begin
      virtpc           <= virtpc + PC_W'(1);
      valid_inprogress <= f_valid_in;
    end
  end

  // Tracks the address of the word now on ic2f_inst.
  always_ff @(posedge clkrst_core_clk) begin
    if (pipe_flush || accept) begin
      virtpc_1a <= virtpc;
    end
  end

  // No request while decode is blocked, none in reset.
  assign f2ic_valid = f_valid_in && f_out_ok && clkrst_core_rst_n;
  assign f2ic_vaddr = virtpc;

  assign f_ready_out = ic2f_ready;
  // Word done when the cache is ready again.
  // Held back while decode stalls, dropped on a flush.
  assign f_valid_out = valid_inprogress && ic2f_ready && f_out_ok && !pipe_flush;

  assign f2d.inst = ic2f_inst;
  assign f2d.pc   = virtpc_1a;

  // PC only moves on an acceptance or a flush.
  a_pc_hold: assert property (
    @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
    !(pipe_flush || accept) |=> $stable(virtpc)
  );

endmodule

// File: logic/icache.sv
`include "core_defines.svh"

module icache import core_pkg::*; (
  input  logic                    clkrst_core_clk,
  input  logic                    clkrst_core_rst_n,
  input  logic                    f2ic_valid,
  input  logic [`CORE_PC_W-1:0]   f2ic_vaddr,
  input  logic                    mem_gnt,
  input  mem_rsp_t                mem_rsp,
  output logic                    ic2f_ready,
  output logic [`CORE_INST_W-1:0] ic2f_inst,
  output logic                    mem_req_lvl,
  output mem_req_t                mem_req
);

  localparam int LINES = `ICACHE_LINES;
  localparam int WORDS = `ICACHE_LINE_WORDS;
  localparam int OFF_W = $clog2(WORDS);
  localparam int IDX_W = $clog2(LINES);
  localparam int TAG_W = `CORE_PC_W - OFF_W - IDX_W;
  localparam int CNT_W = OFF_W + 1;

  typedef enum logic {S_IDLE, S_REFILL} state_t;

  state_t                  state;
  logic [TAG_W-1:0]        tag_arr [LINES];
  logic [`CORE_INST_W-1:0] data_arr [LINES][WORDS];
  logic [LINES-1:0]        line_vld;
  logic [`CORE_INST_W-1:0] inst_q;

  // Address split.
  logic [OFF_W-1:0] req_off;
  logic [IDX_W-1:0] req_idx;
  logic [TAG_W-1:0] req_tag;

  // Refill bookkeeping.
  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;
  logic [CNT_W-1:0] iss_cnt;
  logic [OFF_W-1:0] rsp_cnt;

  logic hit;
  logic accept;
  logic miss_start;
  logic issue;
  logic rsp_take;
  logic last_rsp;

  assign req_off = f2ic_vaddr[OFF_W-1:0];
  assign req_idx = f2ic_vaddr[OFF_W +: IDX_W];
  assign req_tag = f2ic_vaddr[`CORE_PC_W-1 -: TAG_W];

  assign hit        = line_vld[req_idx] && (tag_arr[req_idx] == req_tag);
  assign ic2f_ready = hit && (state == S_IDLE);
  assign accept     = f2ic_valid && ic2f_ready;
  assign miss_start = (state == S_IDLE) && f2ic_valid && !hit;

  // One read per cycle while owning the bus.
  assign issue    = (state == S_REFILL) && mem_gnt && (iss_cnt != CNT_W'(WORDS));
  // Responses only count while this side owns memory.
  assign rsp_take = (state == S_REFILL) && mem_gnt && mem_rsp.valid;
  assign last_rsp = rsp_take && (rsp_cnt == OFF_W'(WORDS - 1));

  assign mem_req_lvl   = (state == S_REFILL);
  assign mem_req.valid = issue;
  assign mem_req.we    = 1'b0;
  assign mem_req.addr  = {fill_tag, fill_idx, iss_cnt[OFF_W-1:0]};
  assign mem_req.wdata = '0;

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      state    <= S_IDLE;
      iss_cnt  <= '0;
      rsp_cnt  <= '0;
      line_vld <= '0;
    end else if (miss_start) begin
      state             <= S_REFILL;
      iss_cnt           <= '0;
      rsp_cnt           <= '0;
      // Line is stale until the last word lands.
      line_vld[req_idx] <= 1'b0;
    end else if (state == S_REFILL) begin
      if (issue) begin
        iss_cnt <= iss_cnt + CNT_W'(1);
      end
      if (rsp_take) begin
        rsp_cnt <= rsp_cnt + OFF_W'(1);
      end
      if (last_rsp) begin
        state              <= S_IDLE;
        line_vld[fill_idx] <= 1'b1;
      end
    end
  end

  // Arrays and refill target.
  always_ff @(posedge clkrst_core_clk) begin
    if (miss_start) begin
      fill_idx <= req_idx;
      fill_tag <= req_tag;
    end
    if (rsp_take) begin
      data_arr[fill_idx][rsp_cnt] <= mem_rsp.rdata;
    end
    if (last_rsp) begin
      tag_arr[fill_idx] <= fill_tag;
    end
  end

  // Hit word held until the next acceptance.
  always_ff @(posedge clkrst_core_clk) begin
    if (accept) begin
      inst_q <= data_arr[req_idx][req_off];
    end
  end

  assign ic2f_inst = inst_q;

  // Fetch never gets a word while a line is being refilled.
  a_no_accept_in_refill: assert property (
    @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
    (state == S_REFILL) |-> !accept
  );

endmodule

// File: logic/dmem_port.sv
`include "core_defines.svh"

module dmem_port import core_pkg::*; (
  input  logic                    clkrst_core_clk,
  input  logic                    clkrst_core_rst_n,
  input  logic                    d_req,
  input  logic                    d_we,
  input  logic [`CORE_PC_W-1:0]   d_addr,
  input  logic [`CORE_INST_W-1:0] d_wdata,
  input  logic                    mem_gnt,
  input  mem_rsp_t                mem_rsp,
  output logic                    d_busy,
  output logic                    d_done,
  output logic [`CORE_INST_W-1:0] d_rdata,
  output logic                    mem_req_lvl,
  output mem_req_t                mem_req
);

  typedef enum logic [1:0] {S_IDLE, S_WAIT_GNT, S_COMPLETE} state_t;

  state_t                  state;
  logic                    acc_we;
  logic [`CORE_PC_W-1:0]   acc_addr;
  logic [`CORE_INST_W-1:0] acc_wdata;
  logic                    issue;

  // Sent once, in the first granted cycle.
  assign issue = (state == S_WAIT_GNT) && mem_gnt;

  // Write ends right after issue.
  // Read ends with its response.
  assign d_done = (state == S_COMPLETE) && (acc_we || (mem_gnt && mem_rsp.valid));

  assign d_busy      = (state != S_IDLE);
  assign mem_req_lvl = (state != S_IDLE);
  assign d_rdata     = mem_rsp.rdata;

  assign mem_req.valid = issue;
  assign mem_req.we    = acc_we;
  assign mem_req.addr  = acc_addr;
  assign mem_req.wdata = acc_wdata;

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:     if (d_req) state <= S_WAIT_GNT;
        S_WAIT_GNT: if (mem_gnt) state <= S_COMPLETE;
        S_COMPLETE: if (d_done) state <= S_IDLE;
        default:    state <= S_IDLE;
      endcase
    end
  end

  // Access captured only when idle.
  always_ff @(posedge clkrst_core_clk) begin
    if ((state == S_IDLE) && d_req) begin
      acc_we    <= d_we;
      acc_addr  <= d_addr;
      acc_wdata <= d_wdata;
    end
  end

  // Load/store unit waits for completion before the next access.
  a_no_req_busy: assert property (
    @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
    d_busy |-> !d_req
  );

endmodule

// File: logic/mem_arbiter.sv
`include "core_defines.svh"

module mem_arbiter import core_pkg::*; (
  input  logic     clkrst_core_clk,
  input  logic     clkrst_core_rst_n,
  input  logic     ic_req_lvl,
  input  mem_req_t ic_req,
  input  logic     dp_req_lvl,
  input  mem_req_t dp_req,
  output logic     ic_gnt,
  output logic     dp_gnt,
  output mem_req_t mem_req
);

  // Set when the data port owned memory last.
  logic last_dp;

  // Owner keeps the bus until it drops its request.
  // Free bus goes to the waiting side that did not own it last.
  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      ic_gnt  <= 1'b0;
      dp_gnt  <= 1'b0;
      last_dp <= 1'b0;
    end else if (ic_gnt) begin
      if (!ic_req_lvl) ic_gnt <= 1'b0;
    end else if (dp_gnt) begin
      if (!dp_req_lvl) dp_gnt <= 1'b0;
    end else if (ic_req_lvl && (!dp_req_lvl || last_dp)) begin
      ic_gnt  <= 1'b1;
      last_dp <= 1'b0;
    end else if (dp_req_lvl) begin
      dp_gnt  <= 1'b1;
      last_dp <= 1'b1;
    end
  end

  // Only the owner reaches memory.
  always_comb begin
    if (ic_gnt) begin
      mem_req = ic_req;
    end else if (dp_gnt) begin
      mem_req = dp_req;
    end else begin
      mem_req = '0;
    end
  end

  // Single owner at any time.
  a_one_owner: assert property (
    @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
    !(ic_gnt && dp_gnt)
  );

endmodule

// File: logic/main_mem.sv
`include "core_defines.svh"

module main_mem import core_pkg::*; (
  input  logic     clkrst_core_clk,
  input  logic     clkrst_core_rst_n,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  localparam int DEPTH = 1 << `MEM_AW;
  localparam int LAT   = `MEM_RD_LAT;

  logic [`CORE_INST_W-1:0] mem [DEPTH];
  logic [`MEM_AW-1:0]      word_idx;
  logic                    rd_fire;
  // Read pipeline, one slot per cycle of latency.
  logic [LAT-1:0]          rd_vld;
  logic [`CORE_INST_W-1:0] rd_data [LAT];

  // Upper address bits wrap.
  assign word_idx = mem_req.addr[`MEM_AW-1:0];
  assign rd_fire  = mem_req.valid && !mem_req.we;

  // Write lands at the request edge.
  always_ff @(posedge clkrst_core_clk) begin
    if (mem_req.valid && mem_req.we) begin
      mem[word_idx] <= mem_req.wdata;
    end
  end

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= (rd_vld << 1) | LAT'(rd_fire);
    end
  end

  // Data walks alongside its valid bit.
  always_ff @(posedge clkrst_core_clk) begin
    rd_data[0] <= mem[word_idx];
    for (int i = 1; i < LAT; i++) begin
      rd_data[i] <= rd_data[i-1];
    end
  end

  assign mem_rsp.valid = rd_vld[LAT-1];
  assign mem_rsp.rdata = rd_data[LAT-1];

endmodule

// File: logic/core_frontend_top.sv
`include "core_defines.svh"

module core_frontend_top import core_pkg::*; (
  input  logic                    clkrst_core_clk,
  input  logic                    clkrst_core_rst_n,
  input  logic [`CORE_PC_W-1:0]   pc2f_newpc,
  input  logic                    pipe_flush,
  input  logic                    f_valid_in,
  input  logic                    f_out_ok,
  output logic                    f_ready_out,
  output logic                    f_valid_out,
  output f2d_t                    f2d,
  input  logic                    d_req,
  input  logic                    d_we,
  input  logic [`CORE_PC_W-1:0]   d_addr,
  input  logic [`CORE_INST_W-1:0] d_wdata,
  output logic                    d_busy,
  output logic                    d_done,
  output logic [`CORE_INST_W-1:0] d_rdata
);

  // Fetch to cache.
  logic                    f2ic_valid;
  logic [`CORE_PC_W-1:0]   f2ic_vaddr;
  logic                    ic2f_ready;
  logic [`CORE_INST_W-1:0] ic2f_inst;

  // Clients to arbiter.
  logic     ic_req_lvl;
  logic     ic_gnt;
  mem_req_t ic_req;
  logic     dp_req_lvl;
  logic     dp_gnt;
  mem_req_t dp_req;

  // Shared memory bus.
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  fetch_stage u_fetch (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .pc2f_newpc        (pc2f_newpc),
    .pipe_flush        (pipe_flush),
    .f_valid_in        (f_valid_in),
    .f_out_ok          (f_out_ok),
    .ic2f_ready        (ic2f_ready),
    .ic2f_inst         (ic2f_inst),
    .f2ic_vaddr        (f2ic_vaddr),
    .f2ic_valid        (f2ic_valid),
    .f_ready_out       (f_ready_out),
    .f_valid_out       (f_valid_out),
    .f2d               (f2d)
  );

  icache u_icache (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .f2ic_valid        (f2ic_valid),
    .f2ic_vaddr        (f2ic_vaddr),
    .mem_gnt           (ic_gnt),
    .mem_rsp           (mem_rsp),
    .ic2f_ready        (ic2f_ready),
    .ic2f_inst         (ic2f_inst),
    .mem_req_lvl       (ic_req_lvl),
    .mem_req           (ic_req)
  );

  dmem_port u_dport (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .d_req             (d_req),
    .d_we              (d_we),
    .d_addr            (d_addr),
    .d_wdata           (d_wdata),
    .mem_gnt           (dp_gnt),
    .mem_rsp           (mem_rsp),
    .d_busy            (d_busy),
    .d_done            (d_done),
    .d_rdata           (d_rdata),
    .mem_req_lvl       (dp_req_lvl),
    .mem_req           (dp_req)
  );

  mem_arbiter u_arb (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .ic_req_lvl        (ic_req_lvl),
    .ic_req            (ic_req),
    .dp_req_lvl        (dp_req_lvl),
    .dp_req            (dp_req),
    .ic_gnt            (ic_gnt),
    .dp_gnt            (dp_gnt),
    .mem_req           (mem_req)
  );

  main_mem u_mem (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .mem_req           (mem_req),
    .mem_rsp           (mem_rsp)
  );

endmodule

// File: verif/tb_checker.sv
`include "core_defines.svh"

module tb_checker import core_pkg::*; (
  input  logic                    clkrst_core_clk,
  input  logic                    clkrst_core_rst_n,
  input  logic                    pipe_flush,
  input  logic [`CORE_PC_W-1:0]   pc2f_newpc,
  input  logic                    f_out_ok,
  input  logic                    f_valid_out,
  input  logic                    f_ready_out,
  input  f2d_t                    f2d,
  input  logic                    d_req,
  input  logic                    d_we,
  input  logic [`CORE_PC_W-1:0]   d_addr,
  input  logic [`CORE_INST_W-1:0] d_wdata,
  input  logic                    d_busy,
  input  logic                    d_done,
  input  logic [`CORE_INST_W-1:0] d_rdata,
  output int                      err_cnt
);

  localparam int DEPTH = 1 << `MEM_AW;

  // Shadow of every completed write.
  logic [`CORE_INST_W-1:0] shadow [DEPTH];
  logic [DEPTH-1:0]        known;
  // Data access taken by the port and not yet done.
  logic                    pend;
  logic                    pend_we;
  logic [`CORE_PC_W-1:0]   pend_addr;
  logic [`CORE_INST_W-1:0] pend_wdata;
  // Next PC decode should see.
  logic [`CORE_PC_W-1:0]   exp_pc;

  initial err_cnt = 0;

  // Memory wraps on the implemented address bits.
  task automatic check_word(input string what, input logic [`CORE_PC_W-1:0] addr,
                            input logic [`CORE_INST_W-1:0] got);
    logic [`MEM_AW-1:0] idx;
    idx = addr[`MEM_AW-1:0];
    if (!known[idx]) begin
      err_cnt++;
      $display("Word at address %h was never written but came back on %s", addr, what);
    end else if (got !== shadow[idx]) begin
      err_cnt++;
      $display("ERR %s at address %h: got %h expected %h", what, addr, got, shadow[idx]);
    end
  endtask

  always @(posedge clkrst_core_clk) begin
    if (!clkrst_core_rst_n) begin
      known  = '0;
      pend   = 1'b0;
      exp_pc = `CORE_PC_W'(`CORE_RESET_PC);
    end else begin
      // Completion first.
      // A new request never overlaps it.
      if (d_done) begin
        if (!pend) begin
          err_cnt++;
          $display("Data port signalled done with no access outstanding");
        end else if (pend_we) begin
          shadow[pend_addr[`MEM_AW-1:0]] = pend_wdata;
          known[pend_addr[`MEM_AW-1:0]]  = 1'b1;
        end else begin
          check_word("d_rdata", pend_addr, d_rdata);
        end
        pend = 1'b0;
      end
      // Port takes a request only when idle.
      if (d_req && !d_busy) begin
        pend       = 1'b1;
        pend_we    = d_we;
        pend_addr  = d_addr;
        pend_wdata = d_wdata;
      end
      // Flush restarts the expected stream.
      if (pipe_flush) begin
        exp_pc = pc2f_newpc;
      end else if (f_valid_out) begin
        if (!f_out_ok) begin
          err_cnt++;
          $display("Fetch presented an instruction while decode held it off");
        end
        // A finished word needs the cache ready again.
        if (!f_ready_out) begin
          err_cnt++;
          $display("ERR f_ready_out: got %h expected %h", f_ready_out, 1'b1);
        end
        if (f2d.pc !== exp_pc) begin
          err_cnt++;
          $display("ERR f2d.pc: got %h expected %h", f2d.pc, exp_pc);
        end
        check_word("f2d.inst", exp_pc, f2d.inst);
        exp_pc = exp_pc + `CORE_PC_W'(1);
      end
    end
  end

endmodule

// File: verif/tb_top.sv
`include "core_defines.svh"

module tb_top import core_pkg::*; ();

  localparam int PC_W          = `CORE_PC_W;
  localparam int N_PHASES      = 8;
  localparam int PHASE_TIMEOUT = 3000;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_FETCH, OP_FLUSH, OP_MIX} op_t;

  // One row of the stimulus table.
  typedef struct packed {
    op_t             op;
    logic [PC_W-1:0] addr;
    logic [7:0]      count;
    logic [PC_W-1:0] flush_pc;
    // f_out_ok per cycle, repeats every 8.
    logic [7:0]      ok_pat;
  } phase_t;

  logic                    clkrst_core_clk = 1'b0;
  logic                    clkrst_core_rst_n;
  logic [PC_W-1:0]         pc2f_newpc;
  logic                    pipe_flush;
  logic                    f_valid_in;
  logic                    f_out_ok;
  logic                    f_ready_out;
  logic                    f_valid_out;
  f2d_t                    f2d;
  logic                    d_req;
  logic                    d_we;
  logic [PC_W-1:0]         d_addr;
  logic [`CORE_INST_W-1:0] d_wdata;
  logic                    d_busy;
  logic                    d_done;
  logic [`CORE_INST_W-1:0] d_rdata;

  phase_t      phases [N_PHASES];
  logic [31:0] lcg_state;
  int          err_cnt;
  int          timeouts;

  always #2 clkrst_core_clk = ~clkrst_core_clk;

  core_frontend_top uut (.*);

  tb_checker u_chk (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Drives one table row until its fetches and data accesses are all seen.
  task automatic run_phase(input int idx);
    phase_t     p;
    logic       fetching;
    logic [2:0] pat_idx;
    int         n_fetch;
    int         n_data;
    int         outs;
    int         issued;
    int         dones;
    int         cyc;
    p        = phases[idx];
    fetching = (p.op == OP_FETCH) || (p.op == OP_FLUSH) || (p.op == OP_MIX);
    n_fetch  = fetching ? int'(p.count) : 0;
    n_data   = (p.op == OP_FETCH || p.op == OP_FLUSH) ? 0 : int'(p.count);
    outs     = 0;
    issued   = 0;
    dones    = 0;
    cyc      = 0;
    while ((outs < n_fetch || dones < n_data) && cyc < PHASE_TIMEOUT) begin
      @(negedge clkrst_core_clk);
      pat_idx    = cyc[2:0];
      pipe_flush = (p.op == OP_FLUSH) && (cyc == 0);
      pc2f_newpc = p.flush_pc;
      if (fetching) begin
        f_valid_in = 1'b1;
      end
      // Decode stops taking words once the row is satisfied.
      f_out_ok = fetching && (outs < n_fetch) && p.ok_pat[pat_idx];
      d_req    = 1'b0;
      if (!d_busy && issued < n_data) begin
        d_req  = 1'b1;
        d_we   = (p.op == OP_WRITE);
        d_addr = p.addr + PC_W'(issued);
        if (p.op == OP_WRITE) begin
          lcg_state = lcg_next(lcg_state);
        end
        d_wdata = (p.op == OP_WRITE) ? lcg_state : '0;
        issued++;
      end
      @(posedge clkrst_core_clk);
      if (f_valid_out) outs++;
      if (d_done) dones++;
      cyc++;
    end
    if (outs < n_fetch || dones < n_data) begin
      timeouts++;
      $display("Timeout in phase %0d: %0d of %0d fetches, %0d of %0d data accesses",
               idx, outs, n_fetch, dones, n_data);
    end
  endtask

  initial begin
    // Code at 0..63, data at 0x200.
    phases[0] = '{OP_WRITE, 28'h000, 8'd64, 28'h000, 8'hff};
    phases[1] = '{OP_WRITE, 28'h200, 8'd16, 28'h000, 8'hff};
    phases[2] = '{OP_READ,  28'h000, 8'd64, 28'h000, 8'hff};
    phases[3] = '{OP_FETCH, 28'h000, 8'd20, 28'h000, 8'hff};
    phases[4] = '{OP_FLUSH, 28'h000, 8'd8,  28'h020, 8'hff};
    phases[5] = '{OP_FETCH, 28'h000, 8'd12, 28'h000, 8'b1011_0110};
    phases[6] = '{OP_MIX,   28'h200, 8'd8,  28'h000, 8'hff};
    phases[7] = '{OP_FLUSH, 28'h000, 8'd12, 28'h004, 8'b1101_1111};
    clkrst_core_rst_n = 1'b0;
    pc2f_newpc        = '0;
    pipe_flush        = 1'b0;
    f_valid_in        = 1'b0;
    f_out_ok          = 1'b0;
    d_req             = 1'b0;
    d_we              = 1'b0;
    d_addr            = '0;
    d_wdata           = '0;
    lcg_state         = 32'd88;
    timeouts          = 0;
    repeat (5) @(posedge clkrst_core_clk);
    @(negedge clkrst_core_clk);
    clkrst_core_rst_n = 1'b1;
    for (int i = 0; i < N_PHASES; i++) begin
      run_phase(i);
      if (timeouts != 0) break;
    end
    @(negedge clkrst_core_clk);
    pipe_flush = 1'b0;
    f_out_ok   = 1'b0;
    d_req      = 1'b0;
    repeat (2) @(posedge clkrst_core_clk);
    $display("Errors: %0d check, %0d timeout", err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+logic
logic/core_pkg.sv
logic/fetch_stage.sv
logic/icache.sv
logic/dmem_port.sv
logic/mem_arbiter.sv
logic/main_mem.sv
logic/core_frontend_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
SIM = obj_dir/sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_top -f tb.f -Mdir obj_dir -o sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
